// File: common/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

	// Command ids as they arrive in the first byte of a host message
	localparam logic [7:0] CMD_GET_VERSION  = 8'd0;
	localparam logic [7:0] CMD_SYNC_TIME    = 8'd1;
	localparam logic [7:0] CMD_GET_TIME     = 8'd2;
	localparam logic [7:0] CMD_CONFIG_PWM   = 8'd3;
	localparam logic [7:0] CMD_SCHEDULE_PWM = 8'd4;
	localparam int         NCMDS            = 5;

	localparam logic [7:0] RSP_GET_VERSION = 8'd0;
	localparam logic [7:0] RSP_GET_TIME    = 8'd1;

	localparam logic UNIT_SYSTEM = 1'b0;
	localparam logic UNIT_PWM    = 1'b1;
	localparam logic UNIT_NONE   = UNIT_SYSTEM; // Never dispatched because cmd_valid rejects it

	localparam int MAX_ARGS     = 4;
	localparam int MAX_PARAMS   = 2;
	localparam int ARG_CNT_BITS = $clog2(MAX_ARGS + 1);

	function automatic logic cmd_valid(input logic [7:0] id);
		return id < NCMDS;
	endfunction

	function automatic logic cmd_unit(input logic [7:0] id);
		case (id)
			CMD_GET_VERSION, CMD_SYNC_TIME, CMD_GET_TIME: return UNIT_SYSTEM;
			CMD_CONFIG_PWM, CMD_SCHEDULE_PWM: return UNIT_PWM;
			default: return UNIT_NONE;
		endcase
	endfunction

	function automatic logic [ARG_CNT_BITS-1:0] cmd_nargs(input logic [7:0] id);
		case (id)
			CMD_SYNC_TIME: return ARG_CNT_BITS'(2); // High word first, then low word
			CMD_CONFIG_PWM, CMD_SCHEDULE_PWM: return ARG_CNT_BITS'(3);
			default: return '0;
		endcase
	endfunction

	function automatic logic cmd_has_response(input logic [7:0] id);
		return id == CMD_GET_VERSION || id == CMD_GET_TIME;
	endfunction

endpackage

// File: common/unit_bus_if.sv
interface unit_bus_if;
	logic [7:0]  cmd;         // Id of the command being executed
	logic        cmd_ready;   // One-cycle start strobe, arg_data holds argument 0
	logic [31:0] arg_data;
	logic        arg_advance; // Unit asks for the next argument
	logic [31:0] param_data;
	logic        param_write;
	logic        cmd_done;    // Also marks param_data as the response id

	modport sequencer (
		output cmd,
		output cmd_ready,
		output arg_data,
		input  arg_advance,
		input  param_data,
		input  param_write,
		input  cmd_done
	);

	modport unit (
		input  cmd,
		input  cmd_ready,
		input  arg_data,
		output arg_advance,
		output param_data,
		output param_write,
		output cmd_done
	);
endinterface

// File: command/vlq_encoder.sv
module vlq_encoder (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [31:0] value,
	output logic [7:0]  byte_data,
	output logic        byte_valid,
	output logic        last,
	output logic        idle
);
	localparam logic [1:0] E_IDLE = 2'd0;
	localparam logic [1:0] E_TRIM = 2'd1; // Dropping leading groups that only repeat the sign
	localparam logic [1:0] E_SEND = 2'd2;

	logic [1:0]  state;
	logic [34:0] sr;          // Five 7-bit groups, most significant on top
	logic [2:0]  groups_left; // Groups still below the top one
	logic        sign_only;

	// The top group may go if the next group alone still decodes to the same sign
	assign sign_only = groups_left != 3'd0 &&
		(sr[34:26] == 9'h1ff || sr[34:26] < 9'd3);

	assign idle       = state == E_IDLE;
	assign byte_valid = state == E_SEND || (state == E_TRIM && !sign_only);
	assign last       = byte_valid && groups_left == 3'd0;
	assign byte_data  = {groups_left != 3'd0, sr[34:28]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= E_IDLE;
		end else begin
			case (state)
				E_IDLE: if (start) state <= E_TRIM;
				E_TRIM, E_SEND: begin
					if (byte_valid)
						state <= (groups_left == 3'd0) ? E_IDLE : E_SEND;
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	// Skipped and sent groups both shift the word up by one group
	always_ff @(posedge clk) begin
		if (state == E_IDLE && start) begin
			sr          <= {{3{value[31]}}, value};
			groups_left <= 3'd4;
		end else if (state != E_IDLE) begin
			sr          <= {sr[27:0], 7'd0};
			groups_left <= groups_left - 3'd1;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> idle)
		else $error("Encoder started while busy");

endmodule

// File: command/command_sequencer.sv
module command_sequencer (
	input  logic          clk,
	input  logic          rst_n,
	input  logic [7:0]    msg_data,
	input  logic          msg_ready,
	output logic          msg_rd_en,
	unit_bus_if.sequencer sys_bus,
	unit_bus_if.sequencer pwm_bus,
	output logic          enc_start,
	output logic [31:0]   enc_value,
	input  logic [7:0]    enc_byte_data,
	input  logic          enc_byte_valid,
	input  logic          enc_last,
	input  logic          enc_idle,
	output logic [7:0]    send_ring_data,
	output logic          send_ring_wr_en,
	output logic [7:0]    send_fifo_data,
	output logic          send_fifo_wr_en
);
	import mcu_cmd_pkg::*;

	localparam int ARG_IDX_BITS   = $clog2(MAX_ARGS);
	localparam int PARAM_IDX_BITS = (MAX_PARAMS > 1) ? $clog2(MAX_PARAMS) : 1;
	localparam int PARAM_CNT_BITS = $clog2(MAX_PARAMS + 1);

	localparam logic [2:0] M_IDLE        = 3'd0;
	localparam logic [2:0] M_ARG_START   = 3'd1;
	localparam logic [2:0] M_ARG_CONT    = 3'd2;
	localparam logic [2:0] M_DISPATCH    = 3'd3;
	localparam logic [2:0] M_WAIT_DONE   = 3'd4;
	localparam logic [2:0] M_SEND_PARAMS = 3'd5;

	logic [2:0]                state;
	logic [7:0]                cmd_id;
	logic                      unit;
	logic [ARG_CNT_BITS-1:0]   nargs;
	logic                      has_rsp;
	logic [31:0]               args [MAX_ARGS];
	logic [ARG_IDX_BITS-1:0]   cur_arg;  // Argument being decoded
	logic [ARG_IDX_BITS-1:0]   arg_ptr;  // Next argument handed to the unit
	logic [31:0]               arg_out;
	logic [31:0]               params [MAX_PARAMS];
	logic [PARAM_CNT_BITS-1:0] nparams;
	logic [PARAM_CNT_BITS-1:0] cur_param;
	logic                      enc_busy;
	logic [7:0]                rsp_len;  // Bytes of the current response so far
	logic                      take_byte;
	logic                      arg_neg;
	logic                      arg_last;
	logic                      sel_advance;
	logic                      sel_param_write;
	logic                      sel_cmd_done;
	logic [31:0]               sel_param_data;

	// Reads alternate with idle cycles so the source has time to present the next byte
	assign take_byte = msg_ready && !msg_rd_en &&
		(state == M_IDLE || state == M_ARG_START || state == M_ARG_CONT);
	assign arg_neg  = msg_data[6] & msg_data[5]; // First VLQ byte carries the sign
	assign arg_last = ARG_CNT_BITS'(cur_arg) + 1'b1 == nargs;

	assign sys_bus.cmd      = cmd_id;
	assign pwm_bus.cmd      = cmd_id;
	assign sys_bus.arg_data = arg_out;
	assign pwm_bus.arg_data = arg_out;

	assign sel_advance     = (unit == UNIT_PWM) ? pwm_bus.arg_advance : sys_bus.arg_advance;
	assign sel_param_write = (unit == UNIT_PWM) ? pwm_bus.param_write : sys_bus.param_write;
	assign sel_cmd_done    = (unit == UNIT_PWM) ? pwm_bus.cmd_done : sys_bus.cmd_done;
	assign sel_param_data  = (unit == UNIT_PWM) ? pwm_bus.param_data : sys_bus.param_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state             <= M_IDLE;
			msg_rd_en         <= 1'b0;
			sys_bus.cmd_ready <= 1'b0;
			pwm_bus.cmd_ready <= 1'b0;
			enc_start         <= 1'b0;
			enc_busy          <= 1'b0;
			send_ring_wr_en   <= 1'b0;
			send_fifo_wr_en   <= 1'b0;
		end else begin
			msg_rd_en         <= take_byte;
			sys_bus.cmd_ready <= 1'b0;
			pwm_bus.cmd_ready <= 1'b0;
			enc_start         <= 1'b0;
			send_ring_wr_en   <= 1'b0;
			send_fifo_wr_en   <= 1'b0;
			case (state)
				M_IDLE: begin
					// Unknown ids are consumed here and produce nothing
					if (take_byte && cmd_valid(msg_data)) begin
						cmd_id  <= msg_data;
						unit    <= cmd_unit(msg_data);
						nargs   <= cmd_nargs(msg_data);
						has_rsp <= cmd_has_response(msg_data);
						cur_arg <= '0;
						state   <= (cmd_nargs(msg_data) == '0) ? M_DISPATCH : M_ARG_START;
					end
				end
				M_ARG_START: begin
					if (take_byte) begin
						args[cur_arg] <= {{25{arg_neg}}, msg_data[6:0]};
						if (msg_data[7]) begin
							state <= M_ARG_CONT;
						end else begin
							cur_arg <= cur_arg + 1'b1;
							state   <= arg_last ? M_DISPATCH : M_ARG_START;
						end
					end
				end
				M_ARG_CONT: begin
					if (take_byte) begin
						args[cur_arg] <= {args[cur_arg][24:0], msg_data[6:0]};
						if (!msg_data[7]) begin
							cur_arg <= cur_arg + 1'b1;
							state   <= arg_last ? M_DISPATCH : M_ARG_START;
						end
					end
				end
				M_DISPATCH: begin
					sys_bus.cmd_ready <= (unit == UNIT_SYSTEM);
					pwm_bus.cmd_ready <= (unit == UNIT_PWM);
					arg_out <= args[0];
					arg_ptr <= ARG_IDX_BITS'(1);
					nparams <= '0;
					state   <= M_WAIT_DONE;
				end
				M_WAIT_DONE: begin
					if (sel_advance) begin
						arg_out <= args[arg_ptr];
						arg_ptr <= arg_ptr + 1'b1;
					end
					if (sel_param_write && nparams < MAX_PARAMS) begin
						params[nparams[PARAM_IDX_BITS-1:0]] <= sel_param_data;
						nparams <= nparams + 1'b1;
					end
					if (sel_cmd_done) begin
						if (has_rsp) begin
							send_ring_data  <= sel_param_data[7:0]; // Response id goes out raw
							send_ring_wr_en <= 1'b1;
							rsp_len   <= 8'd1;
							cur_param <= '0;
							state     <= M_SEND_PARAMS;
						end else begin
							state <= M_IDLE;
						end
					end
				end
				M_SEND_PARAMS: begin
					if (enc_busy) begin
						if (enc_byte_valid) begin
							send_ring_data  <= enc_byte_data;
							send_ring_wr_en <= 1'b1;
							rsp_len  <= rsp_len + 8'd1;
							enc_busy <= !enc_last;
						end
					end else if (cur_param == nparams) begin
						send_fifo_data  <= rsp_len;
						send_fifo_wr_en <= 1'b1;
						state <= M_IDLE;
					end else if (enc_idle) begin
						enc_value <= params[cur_param[PARAM_IDX_BITS-1:0]];
						enc_start <= 1'b1;
						enc_busy  <= 1'b1;
						cur_param <= cur_param + 1'b1;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
		!(sys_bus.cmd_ready && pwm_bus.cmd_ready))
		else $error("cmd_ready raised on both units");

	a_rd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		msg_rd_en |=> !msg_rd_en)
		else $error("msg_rd_en high on two consecutive cycles");

endmodule

// File: design/system_unit.sv
module system_unit #(
	parameter logic [31:0] VERSION = 32'h0001_0000
) (
	input  logic        clk,
	input  logic        rst_n,
	unit_bus_if.unit    bus,
	output logic [31:0] systime_low
);
	import mcu_cmd_pkg::*;

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_SYNC_WAIT = 3'd1;
	localparam logic [2:0] S_SYNC_LOAD = 3'd2;
	localparam logic [2:0] S_VER_DONE  = 3'd3;
	localparam logic [2:0] S_TIME_HI   = 3'd4;
	localparam logic [2:0] S_TIME_DONE = 3'd5;

	logic [2:0]  state;
	logic [63:0] systime;
	logic [31:0] hold_word; // SYNC high word, or GET_TIME high word from the command cycle

	assign systime_low = systime[31:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state           <= S_IDLE;
			systime         <= '0;
			bus.arg_advance <= 1'b0;
			bus.param_write <= 1'b0;
			bus.cmd_done    <= 1'b0;
		end else begin
			bus.arg_advance <= 1'b0;
			bus.param_write <= 1'b0;
			bus.cmd_done    <= 1'b0;
			systime         <= systime + 64'd1;
			case (state)
				S_IDLE: begin
					if (bus.cmd_ready) begin
						case (bus.cmd)
							CMD_SYNC_TIME: begin
								hold_word       <= bus.arg_data;
								bus.arg_advance <= 1'b1;
								state           <= S_SYNC_WAIT;
							end
							CMD_GET_VERSION: begin
								bus.param_data  <= VERSION;
								bus.param_write <= 1'b1;
								state           <= S_VER_DONE;
							end
							CMD_GET_TIME: begin
								bus.param_data  <= systime[31:0]; // Low word goes first
								bus.param_write <= 1'b1;
								hold_word       <= systime[63:32];
								state           <= S_TIME_HI;
							end
							default: bus.cmd_done <= 1'b1;
						endcase
					end
				end
				S_SYNC_WAIT: state <= S_SYNC_LOAD; // Low word reaches arg_data next cycle
				S_SYNC_LOAD: begin
					systime      <= {hold_word, bus.arg_data};
					bus.cmd_done <= 1'b1;
					state        <= S_IDLE;
				end
				S_VER_DONE: begin
					bus.param_data <= {24'd0, RSP_GET_VERSION};
					bus.cmd_done   <= 1'b1;
					state          <= S_IDLE;
				end
				S_TIME_HI: begin
					bus.param_data  <= hold_word;
					bus.param_write <= 1'b1;
					state           <= S_TIME_DONE;
				end
				S_TIME_DONE: begin
					bus.param_data <= {24'd0, RSP_GET_TIME};
					bus.cmd_done   <= 1'b1;
					state          <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: pwm/pwm_unit.sv
module pwm_unit #(
	parameter int NPWM = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	unit_bus_if.unit        bus,
	input  logic [31:0]     systime_low,
	output logic [NPWM-1:0] pwm
);
	import mcu_cmd_pkg::*;

	localparam int CH_BITS = (NPWM > 1) ? $clog2(NPWM) : 1;

	localparam logic [2:0] P_IDLE  = 3'd0;
	localparam logic [2:0] P_WAIT1 = 3'd1;
	localparam logic [2:0] P_ARG1  = 3'd2;
	localparam logic [2:0] P_WAIT2 = 3'd3;
	localparam logic [2:0] P_ARG2  = 3'd4;

	logic [2:0]         state;
	logic [7:0]         cmd_r;
	logic [31:0]        chan;
	logic [31:0]        arg1;   // cycle_ticks for CONFIG, clock for SCHEDULE
	logic [31:0]        cycle_ticks [NPWM];
	logic [31:0]        on_ticks [NPWM];
	logic [31:0]        phase [NPWM];
	logic [NPWM-1:0]    pend_valid;
	logic [31:0]        pend_clock [NPWM];
	logic [31:0]        pend_on [NPWM];
	logic [NPWM-1:0]    pend_hit;
	logic [CH_BITS-1:0] ch;
	logic               chan_ok;

	assign ch      = chan[CH_BITS-1:0];
	assign chan_ok = chan < NPWM;

	// A scheduled duty already drives the output on the matching tick
	for (genvar i = 0; i < NPWM; i++) begin : g_out
		assign pend_hit[i] = pend_valid[i] && systime_low == pend_clock[i];
		assign pwm[i] = phase[i] < (pend_hit[i] ? pend_on[i] : on_ticks[i]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state           <= P_IDLE;
			bus.arg_advance <= 1'b0;
			bus.cmd_done    <= 1'b0;
			pend_valid      <= '0;
			for (int i = 0; i < NPWM; i++) begin
				cycle_ticks[i] <= '0;
				on_ticks[i]    <= '0;
				phase[i]       <= '0;
			end
		end else begin
			bus.arg_advance <= 1'b0;
			bus.cmd_done    <= 1'b0;
			for (int i = 0; i < NPWM; i++) begin
				if (phase[i] + 32'd1 >= cycle_ticks[i])
					phase[i] <= '0;
				else
					phase[i] <= phase[i] + 32'd1;
				if (pend_hit[i]) begin
					on_ticks[i]   <= pend_on[i];
					pend_valid[i] <= 1'b0;
				end
			end
			case (state)
				P_IDLE: begin
					if (bus.cmd_ready) begin
						cmd_r           <= bus.cmd;
						chan            <= bus.arg_data;
						bus.arg_advance <= 1'b1;
						state           <= P_WAIT1;
					end
				end
				P_WAIT1: state <= P_ARG1;
				P_ARG1: begin
					arg1            <= bus.arg_data;
					bus.arg_advance <= 1'b1;
					state           <= P_WAIT2;
				end
				P_WAIT2: state <= P_ARG2;
				P_ARG2: begin
					if (chan_ok && cmd_r == CMD_CONFIG_PWM) begin
						cycle_ticks[ch] <= arg1;
						on_ticks[ch]    <= bus.arg_data;
						phase[ch]       <= '0;
						pend_valid[ch]  <= 1'b0; // Direct setting cancels a pending change
					end else if (chan_ok && cmd_r == CMD_SCHEDULE_PWM) begin
						pend_valid[ch] <= 1'b1;
					end
					bus.cmd_done <= 1'b1;
					state        <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == P_ARG2 && chan_ok && cmd_r == CMD_SCHEDULE_PWM) begin
			pend_clock[ch] <= arg1;
			pend_on[ch]    <= bus.arg_data;
		end
	end

	// PWM commands never produce response parameters
	assign bus.param_write = 1'b0;
	assign bus.param_data  = '0;

	a_chan_range: assert property (@(posedge clk) disable iff (!rst_n)
		state == P_ARG2 |-> chan_ok)
		else $error("PWM channel %0d out of range", chan);

endmodule

// File: design/mcu_command_top.sv
module mcu_command_top #(
	parameter int          NPWM    = 4,
	parameter logic [31:0] VERSION = 32'h0001_0003
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [7:0]      msg_data,
	input  logic            msg_ready,
	output logic            msg_rd_en,
	output logic [7:0]      send_ring_data,
	output logic            send_ring_wr_en,
	output logic [7:0]      send_fifo_data,
	output logic            send_fifo_wr_en,
	output logic [NPWM-1:0] pwm
);
	logic        enc_start;
	logic [31:0] enc_value;
	logic [7:0]  enc_byte_data;
	logic        enc_byte_valid;
	logic        enc_last;
	logic        enc_idle;
	logic [31:0] systime_low;

	unit_bus_if sys_bus ();
	unit_bus_if pwm_bus ();

	command_sequencer u_sequencer (
		.clk             (clk),
		.rst_n           (rst_n),
		.msg_data        (msg_data),
		.msg_ready       (msg_ready),
		.msg_rd_en       (msg_rd_en),
		.sys_bus         (sys_bus),
		.pwm_bus         (pwm_bus),
		.enc_start       (enc_start),
		.enc_value       (enc_value),
		.enc_byte_data   (enc_byte_data),
		.enc_byte_valid  (enc_byte_valid),
		.enc_last        (enc_last),
		.enc_idle        (enc_idle),
		.send_ring_data  (send_ring_data),
		.send_ring_wr_en (send_ring_wr_en),
		.send_fifo_data  (send_fifo_data),
		.send_fifo_wr_en (send_fifo_wr_en)
	);

	vlq_encoder u_encoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (enc_start),
		.value      (enc_value),
		.byte_data  (enc_byte_data),
		.byte_valid (enc_byte_valid),
		.last       (enc_last),
		.idle       (enc_idle)
	);

	system_unit #(
		.VERSION (VERSION)
	) u_system (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (sys_bus),
		.systime_low (systime_low)
	);

	pwm_unit #(
		.NPWM (NPWM)
	) u_pwm (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (pwm_bus),
		.systime_low (systime_low),
		.pwm         (pwm)
	);

endmodule

// File: test/tb_mcu_command.sv
module tb_mcu_command;
	timeunit 1ns;
	timeprecision 1ps;

	import mcu_cmd_pkg::*;

	typedef logic [7:0] byte_q_t [$];

	localparam int          NPWM            = 4;
	localparam logic [31:0] VERSION         = 32'h0002_0107;
	localparam int          RSP_TIMEOUT     = 400;
	localparam int          MSG_BYTE_BUDGET = 300; // Upper bound of host bytes over all tests
	localparam int          PWM_WINDOWS     = (NPWM + 2) * 64 + 320;
	localparam int          WATCHDOG_CYCLES = 10 + MSG_BYTE_BUDGET * 40 + PWM_WINDOWS;

	logic            clk;
	logic            rst_n;
	logic [7:0]      msg_data;
	logic            msg_ready;
	logic            msg_rd_en;
	logic [7:0]      send_ring_data;
	logic            send_ring_wr_en;
	logic [7:0]      send_fifo_data;
	logic            send_fifo_wr_en;
	logic [NPWM-1:0] pwm;

	byte_q_t     msg_q;    // Host bytes not yet consumed with the head on msg_data
	byte_q_t     ring_q;   // Ring bytes of the response being collected
	logic [7:0]  rsp_id_q [$];
	logic [31:0] rsp_p0_q [$];
	logic [31:0] rsp_p1_q [$];
	int          cycle_count = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          seed = 3917;
	int          cfg_cycle [NPWM];
	int          cfg_on [NPWM];

	// Range boundaries of the 1 to 5 byte VLQ forms for both signs
	logic [31:0] edge_vals [19] = '{
		32'h0000_0000, 32'h0000_005F, 32'h0000_0060, 32'hFFFF_FFE0, 32'hFFFF_FFDF,
		32'h0000_2FFF, 32'h0000_3000, 32'hFFFF_F000, 32'hFFFF_EFFF, 32'h0017_FFFF,
		32'h0018_0000, 32'hFFF8_0000, 32'hFFF7_FFFF, 32'h0BFF_FFFF, 32'h0C00_0000,
		32'hFC00_0000, 32'hFBFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000
	};

	mcu_command_top #(
		.NPWM    (NPWM),
		.VERSION (VERSION)
	) dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.msg_data        (msg_data),
		.msg_ready       (msg_ready),
		.msg_rd_en       (msg_rd_en),
		.send_ring_data  (send_ring_data),
		.send_ring_wr_en (send_ring_wr_en),
		.send_fifo_data  (send_fifo_data),
		.send_fifo_wr_en (send_fifo_wr_en),
		.pwm             (pwm)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// Shortest VLQ form with the most significant group first
	function automatic byte_q_t vlq_bytes(input logic [31:0] value);
		byte_q_t q;
		int v;
		int n;
		v = int'(value);
		if (v >= -32'sh20 && v < 32'sh60)
			n = 1;
		else if (v >= -32'sh1000 && v < 32'sh3000)
			n = 2;
		else if (v >= -32'sh8_0000 && v < 32'sh18_0000)
			n = 3;
		else if (v >= -32'sh400_0000 && v < 32'shC00_0000)
			n = 4;
		else
			n = 5;
		for (int i = n - 1; i >= 0; i--)
			q.push_back({i != 0, 7'(v >>> (7 * i))});
		return q;
	endfunction

	// Expected ring bytes of one response are the raw id and then each parameter as VLQ
	function automatic byte_q_t ref_encode(input logic [7:0] id, input int n,
		input logic [31:0] p0, input logic [31:0] p1);
		byte_q_t q;
		byte_q_t part;
		q.push_back(id);
		if (n > 0) begin
			part = vlq_bytes(p0);
			foreach (part[i]) q.push_back(part[i]);
		end
		if (n > 1) begin
			part = vlq_bytes(p1);
			foreach (part[i]) q.push_back(part[i]);
		end
		return q;
	endfunction

	// Host queue model where the next byte shows up on the edge after a read strobe
	always @(posedge clk) begin
		if (msg_rd_en) begin
			if (msg_q.size() == 0) begin
				$display("msg_rd_en raised while no message byte was presented");
				errors++;
			end else begin
				msg_q.delete(0);
			end
		end
		msg_ready <= msg_q.size() > 0;
		msg_data  <= (msg_q.size() > 0) ? msg_q[0] : 8'h00;
	end

	task automatic check_response();
		byte_q_t     exp_q;
		logic [31:0] vals [2];
		logic [31:0] v;
		logic [7:0]  b;
		int          nv;
		int          pos;
		int          want;
		vals[0] = '0;
		vals[1] = '0;
		nv      = 0;
		pos     = 1;
		if (ring_q.size() == 0) begin
			$display("Response length written with no ring bytes before it");
			errors++;
		end else begin
			if (send_fifo_data !== 8'(ring_q.size())) begin
				$display("** Error send_fifo_data got %h expected %h",
					send_fifo_data, 8'(ring_q.size()));
				errors++;
			end
			while (pos < ring_q.size()) begin
				b = ring_q[pos];
				v = {{25{b[6] & b[5]}}, b[6:0]}; // Sign comes from the first byte
				pos++;
				while (b[7] && pos < ring_q.size()) begin
					b = ring_q[pos];
					v = {v[24:0], b[6:0]};
					pos++;
				end
				if (nv < 2)
					vals[nv] = v;
				nv++;
			end
			want = (ring_q[0] == RSP_GET_VERSION) ? 1 : (ring_q[0] == RSP_GET_TIME) ? 2 : -1;
			if (want < 0) begin
				$display("Response carries an unexpected id %h", ring_q[0]);
				errors++;
			end else if (nv != want) begin
				$display("Response id %h carries %0d parameters instead of %0d",
					ring_q[0], nv, want);
				errors++;
			end
			exp_q = ref_encode(ring_q[0], (nv > 2) ? 2 : nv, vals[0], vals[1]);
			if (exp_q.size() != ring_q.size()) begin
				$display("** Error send_ring_data byte count got %h expected %h",
					8'(ring_q.size()), 8'(exp_q.size()));
				errors++;
			end
			foreach (exp_q[i]) begin
				if (i < ring_q.size() && ring_q[i] !== exp_q[i]) begin
					$display("** Error send_ring_data byte %0d got %h expected %h",
						i, ring_q[i], exp_q[i]);
					errors++;
				end
			end
			rsp_id_q.push_back(ring_q[0]);
			rsp_p0_q.push_back(vals[0]);
			rsp_p1_q.push_back(vals[1]);
		end
		ring_q.delete();
	endtask

	always @(posedge clk) begin
		if (send_ring_wr_en)
			ring_q.push_back(send_ring_data);
		if (send_fifo_wr_en)
			check_response();
	end

	task automatic send_cmd(input logic [7:0] id, input int nargs,
		input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] a2);
		byte_q_t     bq;
		logic [31:0] args [3];
		args[0] = a0;
		args[1] = a1;
		args[2] = a2;
		@(negedge clk);
		msg_q.push_back(id);
		for (int i = 0; i < nargs; i++) begin
			bq = vlq_bytes(args[i]);
			foreach (bq[j]) msg_q.push_back(bq[j]);
		end
	endtask

	task automatic wait_response(output logic [7:0] id, output logic [31:0] p0,
		output logic [31:0] p1, output bit ok);
		int waited;
		waited = 0;
		while (rsp_id_q.size() == 0 && waited < RSP_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rsp_id_q.size() == 0) begin
			$display("No response arrived within %0d cycles", RSP_TIMEOUT);
			errors++;
			id = '0;
			p0 = '0;
			p1 = '0;
			ok = 1'b0;
		end else begin
			id = rsp_id_q.pop_front();
			p0 = rsp_p0_q.pop_front();
			p1 = rsp_p1_q.pop_front();
			ok = 1'b1;
		end
	endtask

	// Also serves as the end marker for commands without a response
	task automatic check_version();
		logic [7:0]  id;
		logic [31:0] p0;
		logic [31:0] p1;
		bit          ok;
		send_cmd(CMD_GET_VERSION, 0, '0, '0, '0);
		wait_response(id, p0, p1, ok);
		if (ok) begin
			if (id !== RSP_GET_VERSION) begin
				$display("** Error response id got %h expected %h", id, RSP_GET_VERSION);
				errors++;
			end
			if (p0 !== VERSION) begin
				$display("** Error version got %h expected %h", p0, VERSION);
				errors++;
			end
		end
	endtask

	task automatic sync_and_read(input logic [31:0] hi, input logic [31:0] lo,
		input bit check_hi);
		logic [7:0]  id;
		logic [31:0] p0;
		logic [31:0] p1;
		logic [63:0] loaded;
		logic [63:0] got;
		int          start;
		int          elapsed;
		bit          ok;
		start = cycle_count;
		send_cmd(CMD_SYNC_TIME, 2, hi, lo, '0);
		send_cmd(CMD_GET_TIME, 0, '0, '0, '0);
		wait_response(id, p0, p1, ok);
		if (ok) begin
			elapsed = cycle_count - start;
			loaded  = {hi, lo};
			got     = {p1, p0};
			if (id !== RSP_GET_TIME) begin
				$display("** Error response id got %h expected %h", id, RSP_GET_TIME);
				errors++;
			end
			if (got < loaded || got - loaded >= 64'(elapsed)) begin
				$display("** Error systime got %h expected %h plus under %h",
					got, loaded, elapsed);
				errors++;
			end
			if (check_hi && p1 !== hi) begin
				$display("** Error systime high word got %h expected %h", p1, hi);
				errors++;
			end
		end
	endtask

	task automatic count_high(input int ch, input int len, output int cnt);
		cnt = 0;
		repeat (len) begin
			@(negedge clk);
			if (pwm[ch])
				cnt++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors > errors_before) begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, errors - errors_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	initial begin
		int          mark;
		int          cnt;
		int          t_push;
		int          t_resp;
		int          new_on;
		logic [7:0]  id;
		logic [31:0] p0;
		logic [31:0] p1;
		bit          ok;
		rst_n     = 1'b0;
		msg_data  = 8'h00;
		msg_ready = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		mark = errors;
		check_version();
		end_test("get_version", mark);

		mark = errors;
		for (int i = 0; i < 3; i++)
			sync_and_read($random(seed), {$random(seed)} & 32'h7FFF_FFFF, 1'b1);
		end_test("sync_and_get_time", mark);

		mark = errors;
		foreach (edge_vals[i])
			sync_and_read(edge_vals[i], edge_vals[i], 1'b0);
		end_test("vlq_edges", mark);

		mark = errors;
		for (int ch = 0; ch < NPWM; ch++) begin
			cfg_cycle[ch] = 16 + ({$random(seed)} % 48);
			cfg_on[ch]    = {$random(seed)} % (cfg_cycle[ch] + 1);
			send_cmd(CMD_CONFIG_PWM, 3, 32'(ch), 32'(cfg_cycle[ch]), 32'(cfg_on[ch]));
			check_version();
			count_high(ch, cfg_cycle[ch], cnt);
			if (cnt != cfg_on[ch]) begin
				$display("** Error pwm[%0d] high cycles got %h expected %h",
					ch, cnt, cfg_on[ch]);
				errors++;
			end
		end
		end_test("config_pwm", mark);

		mark = errors;
		new_on = (cfg_on[0] + 1 + ({$random(seed)} % cfg_cycle[0])) % (cfg_cycle[0] + 1);
		t_push = cycle_count;
		send_cmd(CMD_GET_TIME, 0, '0, '0, '0);
		wait_response(id, p0, p1, ok);
		t_resp = cycle_count;
		send_cmd(CMD_SCHEDULE_PWM, 3, 32'd0, p0 + 32'd300, 32'(new_on));
		check_version();
		// The tick lands between t_push + 300 and t_resp + 300
		if (cycle_count + cfg_cycle[0] + 2 >= t_push + 300) begin
			$display("Scheduled tick came too early to observe the old duty");
			errors++;
		end else begin
			count_high(0, cfg_cycle[0], cnt);
			if (cnt != cfg_on[0]) begin
				$display("** Error pwm[0] high cycles before tick got %h expected %h",
					cnt, cfg_on[0]);
				errors++;
			end
		end
		while (cycle_count <= t_resp + 302)
			@(negedge clk);
		count_high(0, cfg_cycle[0], cnt);
		if (cnt != new_on) begin
			$display("** Error pwm[0] high cycles after tick got %h expected %h", cnt, new_on);
			errors++;
		end
		end_test("schedule_pwm", mark);

		mark = errors;
		send_cmd(8'h07, 0, '0, '0, '0);
		send_cmd(8'hFF, 0, '0, '0, '0);
		check_version();
		if (rsp_id_q.size() != 0) begin
			$display("Unknown command ids produced %0d extra responses", rsp_id_q.size());
			errors++;
		end
		end_test("unknown_command", mark);

		$display("Summary: %0d tests run, %0d tests failed, %0d errors",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: list.f
common/mcu_cmd_pkg.sv
common/unit_bus_if.sv
command/vlq_encoder.sv
command/command_sequencer.sv
design/system_unit.sv
pwm/pwm_unit.sv
design/mcu_command_top.sv
test/tb_mcu_command.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary -j 0 -Wno-fatal --top-module tb_mcu_command -f list.f > sim.log 2>&1 &&
	./obj_dir/Vtb_mcu_command >> sim.log 2>&1 ||
	echo "Build or simulation ended abnormally" >> sim.log
grep -q 'Test failures found' sim.log && echo "Simulation FAILED, see sim.log" && exit 1
grep -q 'All tests passed!' sim.log || { echo "Simulation incomplete, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0
